/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
LINTARGS = --lint-only -Wall --timing
TOP      = tb_tx_mac
FILELIST = filelist.f
OUTDIR   = obj_dir
PASS     = NO ERRORS

.PHONY: all run lint clean

all: run

run:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OUTDIR)
	out=$$(./$(OUTDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS)"

lint:
	$(TOOL) $(LINTARGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OUTDIR)

/* filelist.f */
source/tx_mac_pkg.sv
source/frame_intake.sv
source/frame_buffer.sv
source/body_streamer.sv
source/crc32_lanes.sv
source/xgmii_framer.sv
source/tx_mac.sv
tests/tb_tx_mac.sv

/* source/body_streamer.sv */
module body_streamer
    import tx_mac_pkg::*;
(
    input  logic         tx_clk,
    input  logic         tx_rst,
    input  logic         start,
    input  logic         advance,
    input  axis_beat_t   rd_beat,
    input  payload_len_t head_len,
    output logic         rd_en,
    output logic         len_pop,
    output body_word_t   body
);

    logic         active;
    logic [8:0]   wcnt;
    logic [8:0]   last_wcnt;
    logic [1:0]   last_lanes;
    logic         hsel;
    logic         pay_done;
    logic [15:0]  residue;
    logic [111:0] hdr_lanes;
    payload_len_t padded_len;
    payload_len_t body_end;
    logic [31:0]  half_raw;
    logic [3:0]   half_keep;
    logic [31:0]  half;
    logic         step;
    logic         is_last;
    logic         take_half;
    logic         consume;

    // header in lane order with the first wire byte in bits 7:0.
    always_comb begin
        hdr_lanes = '0;
        for (int i = 0; i < mac_header_size; i++) begin
            hdr_lanes[8*i +: 8] = mac_header[8*(13 - i) +: 8];
        end
    end

    assign padded_len = (head_len < min_payload) ? payload_len_t'(min_payload) : head_len;
    assign body_end   = payload_len_t'(mac_header_size) + padded_len - 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload halves
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign half_raw  = hsel ? rd_beat.data[63:32] : rd_beat.data[31:0];
    assign half_keep = hsel ? rd_beat.keep[7:4] : rd_beat.keep[3:0];

    // bytes past the payload read as zero and become the padding.
    always_comb begin
        half = '0;
        for (int j = 0; j < 4; j++) begin
            if (half_keep[j] && !pay_done) begin
                half[8*j +: 8] = half_raw[8*j +: 8];
            end
        end
    end

    assign step      = active & advance;
    assign is_last   = (wcnt == last_wcnt);
    assign take_half = step && (wcnt >= 9'd3); // word 3 is the first to carry payload.
    assign consume   = take_half && !pay_done;
    assign rd_en     = consume && (hsel || !rd_beat.keep[4]);
    assign len_pop   = step && is_last;

    // the header leaves the payload two bytes off the word grid.
    always_comb begin
        if (wcnt < 9'd3) begin
            body.data = hdr_lanes[32*wcnt[1:0] +: 32];
        end else if (wcnt == 9'd3) begin
            body.data = {half[15:0], hdr_lanes[111:96]};
        end else begin
            body.data = {half[15:0], residue};
        end
        body.lanes = is_last ? last_lanes : 2'b11;
        body.last  = active && is_last;
    end

    always_ff @(posedge tx_clk) begin
        if (!tx_rst) begin
            active   <= 1'b0;
            wcnt     <= '0;
            hsel     <= 1'b0;
            pay_done <= 1'b0;
        end else if (start) begin
            active   <= 1'b1;
            wcnt     <= '0;
            hsel     <= 1'b0;
            pay_done <= 1'b0;
        end else if (step) begin
            wcnt <= wcnt + 9'd1;
            if (is_last) active <= 1'b0;
            if (consume) begin
                hsel <= ~rd_en; // a popped beat restarts at its low half.
                if (rd_en && rd_beat.last) pay_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge tx_clk) begin
        if (start) begin
            last_wcnt  <= body_end[10:2];
            last_lanes <= body_end[1:0];
        end
        if (take_half) begin
            residue <= half[31:16];
        end
    end

endmodule

/* source/crc32_lanes.sv */
module crc32_lanes
    import tx_mac_pkg::*;
(
    input  logic        tx_clk,
    input  logic        clear,
    input  logic        update,
    input  logic [31:0] data,
    input  logic [1:0]  lanes,
    output logic [31:0] fcs
);

    logic [31:0] crc;
    logic [31:0] crc_next;

    // bytes are folded lane 0 first and bit 0 first within each byte.
    always_comb begin
        crc_next = crc;
        for (int b = 0; b < 4; b++) begin
            if (b <= lanes) begin
                crc_next = crc_next ^ {24'h0, data[8*b +: 8]};
                for (int k = 0; k < 8; k++) begin
                    if (crc_next[0]) begin
                        crc_next = (crc_next >> 1) ^ crc_poly;
                    end else begin
                        crc_next = crc_next >> 1;
                    end
                end
            end
        end
    end

    assign fcs = ~crc_next; // the presented word is already included.

    always_ff @(posedge tx_clk) begin
        if (clear) begin
            crc <= crc_init;
        end else if (update) begin
            crc <= crc_next;
        end
    end

endmodule

/* source/frame_buffer.sv */
module frame_buffer
    import tx_mac_pkg::*;
(
    input  logic         tx_clk,
    input  logic         tx_rst,
    input  logic         wr_en,
    input  axis_beat_t   wr_beat,
    input  logic         len_push,
    input  payload_len_t frame_len,
    input  logic         rd_en,
    input  logic         len_pop,
    output axis_beat_t   rd_beat,
    output payload_len_t head_len,
    output logic         space,
    output logic         frame_ready
);

    axis_beat_t         mem [fifo_depth];
    payload_len_t       len_mem [len_queue_depth];
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    logic [fifo_aw:0]   count;
    logic [fifo_aw:0]   count_next;
    logic [len_aw-1:0]  len_wr_ptr;
    logic [len_aw-1:0]  len_rd_ptr;
    logic [len_aw:0]    len_count;
    logic [len_aw:0]    len_count_next;

    assign count_next     = count + {{fifo_aw{1'b0}}, wr_en} - {{fifo_aw{1'b0}}, rd_en};
    assign len_count_next = len_count + {{len_aw{1'b0}}, len_push}
                            - {{len_aw{1'b0}}, len_pop};

    // show-ahead read of both queues.
    assign rd_beat     = mem[rd_ptr];
    assign head_len    = len_mem[len_rd_ptr];
    assign frame_ready = (len_count != '0); // a length is queued only once its last beat is in.

    always_ff @(posedge tx_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_beat;
        end
        if (len_push) begin
            len_mem[len_wr_ptr] <= frame_len;
        end
    end

    always_ff @(posedge tx_clk) begin
        if (!tx_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            len_wr_ptr <= '0;
            len_rd_ptr <= '0;
            len_count  <= '0;
            space      <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            if (len_push) len_wr_ptr <= len_wr_ptr + 1'b1;
            if (len_pop) len_rd_ptr <= len_rd_ptr + 1'b1;
            count     <= count_next;
            len_count <= len_count_next;
            // a last beat needs a length slot as well as a word.
            space <= (count_next < fifo_depth) && (len_count_next < len_queue_depth);
        end
    end

endmodule

/* source/frame_intake.sv */
module frame_intake
    import tx_mac_pkg::*;
(
    input  logic         tx_clk,
    input  logic         tx_rst,
    input  axis_beat_t   tx_beat,
    input  logic         tvalid,
    input  logic         space,
    output logic         wr_en,
    output axis_beat_t   wr_beat,
    output logic         len_push,
    output payload_len_t frame_len
);

    payload_len_t run_len;
    payload_len_t beat_bytes;

    // keep is contiguous from lane 0, so counting ones gives the byte count.
    always_comb begin
        beat_bytes = '0;
        for (int i = 0; i < 8; i++) begin
            beat_bytes = beat_bytes + payload_len_t'(tx_beat.keep[i]);
        end
    end

    assign wr_en     = tvalid & space; // a beat is written in the cycle it is accepted.
    assign wr_beat   = tx_beat;
    assign frame_len = run_len + beat_bytes;
    assign len_push  = wr_en & tx_beat.last;

    always_ff @(posedge tx_clk) begin
        if (!tx_rst) begin
            run_len <= '0;
        end else if (wr_en) begin
            if (tx_beat.last) begin
                run_len <= '0;
            end else begin
                run_len <= frame_len;
            end
        end
    end

endmodule

/* source/tx_mac.sv */
module tx_mac
    import tx_mac_pkg::*;
(
    input  logic        tx_clk,
    input  logic        tx_rst,
    input  axis_beat_t  tx_beat,
    input  logic        tvalid,
    output logic        tready,
    input  logic        pcs_ready,
    output xgmii_word_t xgmii
);

    logic         wr_en;
    axis_beat_t   wr_beat;
    logic         len_push;
    payload_len_t frame_len;
    logic         rd_en;
    logic         len_pop;
    axis_beat_t   rd_beat;
    payload_len_t head_len;
    logic         frame_ready;
    logic         start;
    logic         advance;
    body_word_t   body;
    logic         crc_clear;
    logic         crc_update;
    logic [31:0]  crc_data;
    logic [1:0]   crc_lanes;
    logic [31:0]  fcs;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    frame_intake i_intake (
        .tx_clk    (tx_clk),
        .tx_rst    (tx_rst),
        .tx_beat   (tx_beat),
        .tvalid    (tvalid),
        .space     (tready),
        .wr_en     (wr_en),
        .wr_beat   (wr_beat),
        .len_push  (len_push),
        .frame_len (frame_len)
    );

    frame_buffer i_buffer (
        .tx_clk      (tx_clk),
        .tx_rst      (tx_rst),
        .wr_en       (wr_en),
        .wr_beat     (wr_beat),
        .len_push    (len_push),
        .frame_len   (frame_len),
        .rd_en       (rd_en),
        .len_pop     (len_pop),
        .rd_beat     (rd_beat),
        .head_len    (head_len),
        .space       (tready), // tready is the buffer's space flag.
        .frame_ready (frame_ready)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    body_streamer i_streamer (
        .tx_clk   (tx_clk),
        .tx_rst   (tx_rst),
        .start    (start),
        .advance  (advance),
        .rd_beat  (rd_beat),
        .head_len (head_len),
        .rd_en    (rd_en),
        .len_pop  (len_pop),
        .body     (body)
    );

    xgmii_framer i_framer (
        .tx_clk      (tx_clk),
        .tx_rst      (tx_rst),
        .pcs_ready   (pcs_ready),
        .frame_ready (frame_ready),
        .body        (body),
        .fcs         (fcs),
        .start       (start),
        .advance     (advance),
        .crc_clear   (crc_clear),
        .crc_update  (crc_update),
        .crc_data    (crc_data),
        .crc_lanes   (crc_lanes),
        .xgmii       (xgmii)
    );

    crc32_lanes i_crc (
        .tx_clk (tx_clk),
        .clear  (crc_clear),
        .update (crc_update),
        .data   (crc_data),
        .lanes  (crc_lanes),
        .fcs    (fcs)
    );

endmodule

/* source/tx_mac_pkg.sv */
package tx_mac_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // xgmii control codes and frame bytes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [7:0] xgmii_idle      = 8'h07;
    localparam logic [7:0] xgmii_start     = 8'hfb;
    localparam logic [7:0] xgmii_terminate = 8'hfd;
    localparam logic [7:0] preamble_byte   = 8'h55;
    localparam logic [7:0] sfd_byte        = 8'hd5;

    localparam logic [11:0] min_payload     = 12'd46;
    localparam logic [11:0] max_payload     = 12'd1500;
    localparam logic [4:0]  mac_header_size = 5'd14;
    localparam logic [4:0]  ifg_bytes       = 5'd12;

    localparam logic [47:0] dest_mac   = 48'h00_11_22_33_44_55;
    localparam logic [47:0] src_mac    = 48'haa_bb_cc_dd_ee_ff;
    localparam logic [15:0] ether_type = 16'h0800;
    // the first byte on the wire sits in the top bits.
    localparam logic [111:0] mac_header = {dest_mac, src_mac, ether_type};

    localparam logic [31:0] crc_init = 32'hffff_ffff;
    localparam logic [31:0] crc_poly = 32'hedb8_8320; // reflected form of 0x04c11db7.

    // two maximum frames fit with room to spare.
    localparam int fifo_depth      = 512;
    localparam int fifo_aw         = $clog2(fifo_depth);
    localparam int len_queue_depth = 8;
    localparam int len_aw          = $clog2(len_queue_depth);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [$clog2(max_payload + 1) - 1:0] payload_len_t;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
    } axis_beat_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  lanes; // valid low lanes minus one.
        logic        last;
    } body_word_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  ctl;
    } xgmii_word_t;

    localparam xgmii_word_t xgmii_idle_word = '{data: {4{xgmii_idle}}, ctl: 4'hf};

endpackage

/* source/xgmii_framer.sv */
module xgmii_framer
    import tx_mac_pkg::*;
(
    input  logic        tx_clk,
    input  logic        tx_rst,
    input  logic        pcs_ready,
    input  logic        frame_ready,
    input  body_word_t  body,
    input  logic [31:0] fcs,
    output logic        start,
    output logic        advance,
    output logic        crc_clear,
    output logic        crc_update,
    output logic [31:0] crc_data,
    output logic [1:0]  crc_lanes,
    output xgmii_word_t xgmii
);

    typedef enum logic [2:0] {
        s_idle,
        s_preamble,
        s_body,
        s_tail,
        s_terminate,
        s_gap
    } state_t;

    state_t      state;
    logic [63:0] hold_data;
    logic [7:0]  hold_ctl;
    logic [4:0]  ifg_cnt;
    logic [2:0]  last_bytes;
    logic [5:0]  last_shift;
    logic [95:0] body_mask;
    logic [95:0] tail_data;
    logic [11:0] tail_ctl;

    assign start      = pcs_ready && (state == s_idle) && frame_ready;
    assign advance    = pcs_ready && (state == s_body);
    assign crc_clear  = start;
    assign crc_update = advance;
    assign crc_data   = body.data;
    assign crc_lanes  = body.lanes;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame end
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the last body bytes are followed by the fcs, the terminate code and idles.
    assign last_bytes = {1'b0, body.lanes} + 3'd1;
    assign last_shift = {last_bytes, 3'b000};
    assign body_mask  = ~({96{1'b1}} << last_shift);
    assign tail_data  = ({{7{xgmii_idle}}, xgmii_terminate, fcs} << last_shift)
                        | ({64'h0, body.data} & body_mask);
    assign tail_ctl   = {8'hff, 4'h0} << last_bytes;

    always_ff @(posedge tx_clk) begin
        if (!tx_rst) begin
            state   <= s_idle;
            xgmii   <= xgmii_idle_word;
            ifg_cnt <= '0;
        end else if (pcs_ready) begin // a low pcs_ready freezes the whole output side.
            case (state)
                s_idle: begin
                    if (frame_ready) begin
                        xgmii <= '{data: {{3{preamble_byte}}, xgmii_start}, ctl: 4'b0001};
                        state <= s_preamble;
                    end else begin
                        xgmii <= xgmii_idle_word;
                    end
                end
                s_preamble: begin
                    xgmii <= '{data: {sfd_byte, {3{preamble_byte}}}, ctl: 4'b0000};
                    state <= s_body;
                end
                s_body: begin
                    if (body.last) begin
                        xgmii     <= '{data: tail_data[31:0], ctl: tail_ctl[3:0]};
                        hold_data <= tail_data[95:32];
                        hold_ctl  <= tail_ctl[11:4];
                        state     <= s_tail;
                    end else begin
                        xgmii <= '{data: body.data, ctl: 4'b0000};
                    end
                end
                s_tail: begin
                    xgmii   <= '{data: hold_data[31:0], ctl: hold_ctl[3:0]};
                    ifg_cnt <= 5'($countones(hold_ctl[3:0])); // terminate and idles so far.
                    if (hold_ctl[3:0] == 4'h0) begin
                        state <= s_terminate; // the fcs filled the whole word.
                    end else begin
                        state <= s_gap;
                    end
                end
                s_terminate: begin
                    xgmii   <= '{data: hold_data[63:32], ctl: hold_ctl[7:4]};
                    ifg_cnt <= 5'd4;
                    state   <= s_gap;
                end
                s_gap: begin
                    xgmii   <= xgmii_idle_word;
                    ifg_cnt <= ifg_cnt + 5'd4;
                    if (ifg_cnt + 5'd4 >= ifg_bytes) begin
                        state <= s_idle;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

endmodule

/* tests/tb_tx_mac.sv */
module tb_tx_mac
    import tx_mac_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_frames      = 41;
    localparam int big_frame       = 20; // this one carries 1500 payload bytes.
    localparam int drain_limit     = 20000;
    localparam int watchdog_cycles = num_frames * 1600 + drain_limit + 1000;

    localparam xgmii_word_t start_word = '{data: {{3{preamble_byte}}, xgmii_start},
                                           ctl: 4'b0001};

    logic        tx_clk;
    logic        tx_rst;
    axis_beat_t  tx_beat;
    logic        tvalid;
    logic        tready;
    logic        pcs_ready;
    xgmii_word_t xgmii;

    logic [7:0] pay_buf [1500];
    logic [7:0] exp_bytes [$];
    int         exp_len [$];
    int         exp_pay [$];
    int         frames_done;
    int         cur_len;
    int         cur_pay;
    int         rx_cnt;

    tx_mac i_dut (
        .tx_clk    (tx_clk),
        .tx_rst    (tx_rst),
        .tx_beat   (tx_beat),
        .tvalid    (tvalid),
        .tready    (tready),
        .pcs_ready (pcs_ready),
        .xgmii     (xgmii)
    );

    initial begin
        tx_clk = 1'b0;
        forever #20 tx_clk = ~tx_clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_len(input string name, input payload_len_t exp,
                               input payload_len_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic compare_word(input string name, input xgmii_word_t exp,
                                input xgmii_word_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reflected crc-32, one byte at a time, bit 0 first.
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'h0, b};
        for (int k = 0; k < 8; k++) begin
            if (c[0]) begin
                c = (c >> 1) ^ 32'hedb8_8320;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    task automatic build_frame(input int len);
        logic [111:0] hdr;
        logic [31:0]  crc;
        logic [7:0]   b;
        int           padded;
        hdr    = {dest_mac, src_mac, ether_type};
        crc    = 32'hffff_ffff;
        padded = (len < 46) ? 46 : len;
        for (int i = 0; i < 6; i++) begin
            exp_bytes.push_back(preamble_byte);
        end
        exp_bytes.push_back(sfd_byte);
        for (int i = 0; i < 14 + padded; i++) begin
            if (i < 14) begin
                b = hdr[8*(13 - i) +: 8]; // destination mac goes out first.
            end else if (i < 14 + len) begin
                b = pay_buf[i - 14];
            end else begin
                b = 8'h00;
            end
            exp_bytes.push_back(b);
            crc = crc_step(crc, b);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            exp_bytes.push_back(crc[8*i +: 8]);
        end
        exp_len.push_back(7 + 14 + padded + 4);
        exp_pay.push_back(len);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_beat(input axis_beat_t beat);
        logic taken;
        while ($urandom_range(0, 3) == 0) begin
            tvalid <= 1'b0;
            @(posedge tx_clk);
        end
        tx_beat <= beat;
        tvalid  <= 1'b1;
        taken   = 1'b0;
        while (!taken) begin
            @(negedge tx_clk);
            taken = tready; // this is the level the next edge sees.
            @(posedge tx_clk);
        end
    endtask

    task automatic send_frame(input int len);
        axis_beat_t beat;
        int         idx;
        for (int i = 0; i < len; i++) begin
            pay_buf[i] = 8'($urandom());
        end
        build_frame(len);
        for (int n = 0; n < (len + 7) / 8; n++) begin
            beat.data = {$urandom(), $urandom()}; // unused lanes carry noise.
            beat.keep = 8'hff;
            for (int k = 0; k < 8; k++) begin
                idx = 8 * n + k;
                if (idx < len) begin
                    beat.data[8*k +: 8] = pay_buf[idx];
                end else begin
                    beat.keep[k] = 1'b0;
                end
            end
            beat.last = (8 * n + 8 >= len);
            send_beat(beat);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // xgmii monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic take_byte(input logic [7:0] b);
        string region;
        if (rx_cnt >= cur_len) begin
            fail_run("a frame ran on past its expected end");
        end else begin
            if (rx_cnt < 7) begin
                region = "preamble";
            end else if (rx_cnt < 21) begin
                region = "header";
            end else if (rx_cnt < 21 + cur_pay) begin
                region = "payload";
            end else if (rx_cnt < cur_len - 4) begin
                region = "padding";
            end else begin
                region = "fcs";
            end
            compare_byte(region, exp_bytes.pop_front(), b);
            rx_cnt++;
        end
    endtask

    task automatic end_frame();
        if (cur_pay < 46) begin
            compare_len("padded length", payload_len_t'(8 + 14 + 46 + 4 - 1),
                        payload_len_t'(rx_cnt));
        end else begin
            compare_len("frame length", payload_len_t'(cur_len), payload_len_t'(rx_cnt));
        end
        frames_done++;
    endtask

    initial begin : monitor
        xgmii_word_t last_word;
        xgmii_word_t w;
        logic        fresh;
        logic        in_frame;
        int          gap_cnt;
        int          first;
        frames_done = 0;
        in_frame    = 1'b0;
        gap_cnt     = 0;
        wait (tx_rst === 1'b1);
        @(negedge tx_clk);
        last_word = xgmii;
        fresh     = pcs_ready;
        forever begin
            @(negedge tx_clk);
            w     = xgmii;
            first = 0;
            if (!fresh) begin
                compare_word("hold on pcs_ready low", last_word, w);
            end else begin
                if (!in_frame && w.ctl[0] && w.data[7:0] == xgmii_start) begin
                    compare_word("start word", start_word, w);
                    if (frames_done > 0 && gap_cnt < 12) begin
                        fail_run("fewer than 12 control bytes came between two frames");
                    end else if (exp_len.size() == 0) begin
                        fail_run("a frame arrived that was never sent");
                    end else begin
                        cur_len  = exp_len.pop_front();
                        cur_pay  = exp_pay.pop_front();
                        rx_cnt   = 0;
                        in_frame = 1'b1;
                        first    = 1;
                    end
                end else if (!in_frame && frames_done == 0) begin
                    compare_word("idle after reset", xgmii_idle_word, w);
                end
                for (int l = first; l < 4; l++) begin
                    if (in_frame && !w.ctl[l]) begin
                        take_byte(w.data[8*l +: 8]);
                    end else if (in_frame) begin
                        compare_byte("terminate", xgmii_terminate, w.data[8*l +: 8]);
                        end_frame();
                        in_frame = 1'b0;
                        gap_cnt  = 1; // terminate counts toward the gap.
                    end else if (!w.ctl[l]) begin
                        fail_run("a data byte appeared outside a frame");
                    end else begin
                        compare_byte("inter-frame idle", xgmii_idle, w.data[8*l +: 8]);
                        gap_cnt++;
                    end
                end
            end
            last_word = w;
            fresh     = pcs_ready;
        end
    end

    // tready stays low on every cycle the DUT spends in reset.
    initial begin : reset_check
        @(posedge tx_clk);
        while (tx_rst !== 1'b1) begin
            @(negedge tx_clk);
            compare_flag("tready in reset", 1'b0, tready);
            @(posedge tx_clk);
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge tx_clk);
        fail_run("the run hung and did not finish within its cycle limit");
    end

    initial begin : stimulus
        int cycles;
        void'($urandom(32'he846_17da));
        tx_rst    = 1'b0;
        tvalid    = 1'b0;
        tx_beat   = '0;
        pcs_ready = 1'b1;
        repeat (5) @(posedge tx_clk);
        tx_rst <= 1'b1;
        fork
            forever begin
                @(posedge tx_clk);
                pcs_ready <= ($urandom_range(0, 5) != 0);
            end
        join_none
        for (int f = 0; f < num_frames; f++) begin
            if (f == big_frame) begin
                send_frame(1500);
            end else begin
                send_frame($urandom_range(1, 120));
            end
        end
        tvalid <= 1'b0;
        cycles = 0;
        while (frames_done < num_frames && cycles < drain_limit) begin
            @(posedge tx_clk);
            cycles++;
        end
        repeat (100) @(posedge tx_clk); // a duplicated frame would start in here.
        if (frames_done != num_frames) begin
            fail_run($sformatf("only %0d of %0d frames arrived", frames_done, num_frames));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule
